//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // first fetch address after reset
    localparam logic [31:0] RESET_PC = 32'hbfc0_0000;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_t;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target;
        } j;
    } instr_t;

endpackage

`default_nettype wire

//--- hdl/sram_if.sv
`timescale 1ns/1ps
`default_nettype none

// one sram port, read data valid the cycle after en
interface sram_if;
    logic        en;
    logic [3:0]  wen;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;

    // core side issues the request
    modport master (output en, output wen, output addr, output wdata, input rdata);
    // memory side returns the word
    modport slave (input en, input wen, input addr, input wdata, output rdata);
endinterface

`default_nettype wire

//--- hdl/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

// writeback bundle, feeds regfile write port and debug outputs
interface wb_if;
    logic [31:0] pc;
    logic [3:0]  wen;
    logic [4:0]  wnum;
    logic [31:0] wdata;

    // driven from the W stage
    modport source (output pc, output wen, output wnum, output wdata);
    // regfile and debug ports
    modport sink (input pc, input wen, input wnum, input wdata);
endinterface

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  alu_op_t     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [4:0]  shamt,
    output logic [31:0] y
);

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            // signed compare, result in bit 0
            ALU_SLT: y = {31'b0, $signed(a) < $signed(b)};
            // shifts take rt, amount from the shamt field
            ALU_SLL: y = b << shamt;
            ALU_SRL: y = b >> shamt;
            // immediate into the upper half
            ALU_LUI: y = {b[15:0], 16'h0000};
            default: y = a + b;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    wb_if.sink          wb
);

    logic [31:0] regs [32];

    // write at the edge, r0 never stored
    always_ff @(posedge clk) begin
        if (wb.wen != 4'h0 && wb.wnum != 5'd0) begin
            regs[wb.wnum] <= wb.wdata;
        end
    end

    // async reads, r0 hardwired to zero
    assign rd1 = (ra1 == 5'd0) ? 32'h0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'h0 : regs[ra2];

    // W stage must never request a write to r0
    assert property (@(posedge clk) disable iff (!rst_n)
        (wb.wen != 4'h0) |-> (wb.wnum != 5'd0))
        else $error("regfile: write enable with wnum zero");

endmodule

`default_nettype wire

//--- hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder
    import cpu_pkg::*;
(
    input  instr_t  instr,
    output alu_op_t alu_op,
    output logic    use_imm,
    output logic    imm_zero_ext,
    output logic    reg_write,
    output logic    dst_rt,
    output logic    is_load,
    output logic    is_store,
    output logic    is_beq,
    output logic    is_bne,
    output logic    is_j
);

    always_comb begin
        // defaults give a nop
        alu_op       = ALU_ADD;
        use_imm      = 1'b0;
        imm_zero_ext = 1'b0;
        reg_write    = 1'b0;
        dst_rt       = 1'b0;
        is_load      = 1'b0;
        is_store     = 1'b0;
        is_beq       = 1'b0;
        is_bne       = 1'b0;
        is_j         = 1'b0;
        case (instr.r.op)
            OP_SPECIAL: begin
                // r-type writes rd
                reg_write = 1'b1;
                case (instr.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    // unknown funct stays a nop
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                // i-type arithmetic writes rt
                use_imm   = 1'b1;
                reg_write = 1'b1;
                dst_rt    = 1'b1;
                case (instr.i.op)
                    OP_SLTI: alu_op = ALU_SLT;
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    OP_XORI: alu_op = ALU_XOR;
                    OP_LUI:  alu_op = ALU_LUI;
                    default: alu_op = ALU_ADD;
                endcase
                // logic immediates are zero extended
                imm_zero_ext = (instr.i.op == OP_ANDI) || (instr.i.op == OP_ORI) ||
                               (instr.i.op == OP_XORI);
            end
            OP_LW: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                dst_rt    = 1'b1;
                is_load   = 1'b1;
            end
            OP_SW: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            OP_BEQ: is_beq = 1'b1;
            OP_BNE: is_bne = 1'b1;
            OP_J:   is_j   = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    sram_if.master      imem,
    sram_if.master      dmem,
    wb_if.source        wb,
    output logic [4:0]  ra1,
    output logic [4:0]  ra2,
    input  logic [31:0] rd1,
    input  logic [31:0] rd2
);

    // F stage
    logic [31:0] pc;
    logic [31:0] pc_next;

    // E stage takes its word straight from imem
    logic [31:0] e_pc;
    logic        e_valid;
    instr_t      e_instr;
    alu_op_t     alu_op;
    logic        use_imm;
    logic        imm_zero_ext;
    logic        reg_write;
    logic        dst_rt;
    logic        is_load;
    logic        is_store;
    logic        is_beq;
    logic        is_bne;
    logic        is_j;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] imm_ext;
    logic [31:0] alu_y;
    logic [31:0] slot_pc;
    logic [31:0] br_target;
    logic [31:0] j_target;
    logic        taken;
    logic [4:0]  e_dst;
    logic        e_wr;

    // W stage
    logic [31:0] w_pc;
    logic [4:0]  w_dst;
    logic [31:0] w_result;
    logic        w_is_load;
    logic        w_valid;
    logic [31:0] w_data;

    // bubble after reset decodes as sll r0 which is a nop
    assign e_instr = e_valid ? instr_t'(imem.rdata) : instr_t'(32'h0);

    decoder u_decoder (
        .instr        (e_instr),
        .alu_op       (alu_op),
        .use_imm      (use_imm),
        .imm_zero_ext (imm_zero_ext),
        .reg_write    (reg_write),
        .dst_rt       (dst_rt),
        .is_load      (is_load),
        .is_store     (is_store),
        .is_beq       (is_beq),
        .is_bne       (is_bne),
        .is_j         (is_j)
    );

    assign ra1 = e_instr.r.rs;
    assign ra2 = e_instr.r.rt;

    // W result or load data bypasses the regfile
    assign w_data = w_is_load ? dmem.rdata : w_result;
    assign src_a  = (w_valid && w_dst == e_instr.r.rs) ? w_data : rd1;
    assign src_b  = (w_valid && w_dst == e_instr.r.rt) ? w_data : rd2;

    assign imm_ext = imm_zero_ext ? {16'h0000, e_instr.i.imm}
                                  : {{16{e_instr.i.imm[15]}}, e_instr.i.imm};

    alu u_alu (
        .op    (alu_op),
        .a     (src_a),
        .b     (use_imm ? imm_ext : src_b),
        .shamt (e_instr.r.shamt),
        .y     (alu_y)
    );

    // pc already points at the delay slot while a branch sits in E
    assign slot_pc   = e_pc + 32'd4;
    assign br_target = slot_pc + {{14{e_instr.i.imm[15]}}, e_instr.i.imm, 2'b00};
    assign j_target  = {slot_pc[31:28], e_instr.j.target, 2'b00};
    assign taken     = is_j || (is_beq && src_a == src_b) || (is_bne && src_a != src_b);
    assign pc_next   = !taken ? pc + 32'd4 : (is_j ? j_target : br_target);

    assign e_dst = dst_rt ? e_instr.r.rt : e_instr.r.rd;
    assign e_wr  = reg_write && e_dst != 5'd0;

    // fetch port always reads
    assign imem.en    = 1'b1;
    assign imem.wen   = 4'h0;
    assign imem.addr  = pc;
    assign imem.wdata = 32'h0;

    // data access issued from E with load data landing in W
    assign dmem.en    = is_load || is_store;
    assign dmem.wen   = is_store ? 4'hf : 4'h0;
    assign dmem.addr  = alu_y;
    assign dmem.wdata = src_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= RESET_PC;
            e_valid <= 1'b0;
            w_valid <= 1'b0;
        end else begin
            pc      <= pc_next;
            e_valid <= 1'b1;
            w_valid <= e_wr;
        end
    end

    // stage payload qualified by the valid bits
    always_ff @(posedge clk) begin
        e_pc      <= pc;
        w_pc      <= e_pc;
        w_dst     <= e_dst;
        w_result  <= alu_y;
        w_is_load <= is_load;
    end

    assign wb.pc    = w_pc;
    assign wb.wen   = {4{w_valid}};
    assign wb.wnum  = w_dst;
    assign wb.wdata = w_data;

    // word accesses only
    assert property (@(posedge clk) disable iff (!rst_n)
        dmem.en |-> (dmem.addr[1:0] == 2'b00))
        else $error("datapath: unaligned data address");

endmodule

`default_nettype wire

//--- hdl/mycpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mycpu_top (
    input  logic        clk,
    input  logic        rst_n,
    // instruction sram
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    // data sram
    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    // writeback trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    sram_if imem ();
    sram_if dmem ();
    wb_if   wb ();

    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic [31:0] rd1;
    logic [31:0] rd2;

    datapath u_datapath (
        .clk   (clk),
        .rst_n (rst_n),
        .imem  (imem.master),
        .dmem  (dmem.master),
        .wb    (wb.source),
        .ra1   (ra1),
        .ra2   (ra2),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    // same wb bundle drives the write port and the trace
    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (ra1),
        .ra2   (ra2),
        .rd1   (rd1),
        .rd2   (rd2),
        .wb    (wb.sink)
    );

    assign inst_sram_en    = imem.en;
    assign inst_sram_wen   = imem.wen;
    assign inst_sram_addr  = imem.addr;
    assign inst_sram_wdata = imem.wdata;
    assign imem.rdata      = inst_sram_rdata;

    assign data_sram_en    = dmem.en;
    assign data_sram_wen   = dmem.wen;
    assign data_sram_addr  = dmem.addr;
    assign data_sram_wdata = dmem.wdata;
    assign dmem.rdata      = data_sram_rdata;

    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wen   = wb.wen;
    assign debug_wb_rf_wnum  = wb.wnum;
    assign debug_wb_rf_wdata = wb.wdata;

endmodule

`default_nettype wire

//--- tb/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
    import cpu_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_RUNS    = 4;
    localparam int PROLOGUE    = 31;
    localparam int BODY_LEN    = 200;
    localparam int IMEM_WORDS  = 256;
    localparam int RUN_CYCLES  = 500;
    localparam int TAIL_CYCLES = 8;
    localparam logic [31:0] SEED = 32'ha92572de;

    logic        clk;
    logic        rst_n;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // program image and data region seen by the DUT
    logic [31:0] prog [IMEM_WORDS];
    logic [31:0] ram [64];
    // reference model state
    logic [31:0] mregs [32];
    logic [31:0] mdata [64];
    logic [31:0] final_pc;
    // expected traffic from the model in program order
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_val [$];
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];

    logic [31:0] inst_next;
    logic [31:0] data_next;
    logic [31:0] fetch_d1;
    logic [31:0] fetch_d2;
    int          cyc;
    int          errors;

    mycpu_top dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("FAIL %0t ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    function automatic logic [4:0] random_reg();
        // small register set gives lots of dependences
        return 5'($urandom_range(7, 0));
    endfunction

    function automatic logic [31:0] make_rtype(logic [5:0] funct, logic [4:0] rs,
                                               logic [4:0] rt, logic [4:0] rd,
                                               logic [4:0] shamt);
        instr_t ins;
        ins.r.op    = OP_SPECIAL;
        ins.r.rs    = rs;
        ins.r.rt    = rt;
        ins.r.rd    = rd;
        ins.r.shamt = shamt;
        ins.r.funct = funct;
        return ins;
    endfunction

    function automatic logic [31:0] make_itype(logic [5:0] op, logic [4:0] rs,
                                               logic [4:0] rt, logic [15:0] imm);
        instr_t ins;
        ins.i.op  = op;
        ins.i.rs  = rs;
        ins.i.rt  = rt;
        ins.i.imm = imm;
        return ins;
    endfunction

    function automatic logic [31:0] make_jump(logic [31:0] target);
        instr_t ins;
        ins.j.op     = OP_J;
        ins.j.target = target[27:2];
        return ins;
    endfunction

    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        logic [31:0] off;
        off = addr - RESET_PC;
        // outside the image reads as nop
        if (off < 32'(IMEM_WORDS * 4)) begin
            return prog[off[9:2]];
        end
        return 32'h0;
    endfunction

    function automatic logic [31:0] random_plain();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [15:0] offs;
        logic [31:0] word;
        rs   = random_reg();
        rt   = random_reg();
        rd   = random_reg();
        imm  = 16'($urandom);
        // base r0 with an aligned offset inside the 64 word region
        offs = {8'h00, 6'($urandom_range(63, 0)), 2'b00};
        case ($urandom_range(16, 0))
            0:  word = make_rtype(FN_ADDU, rs, rt, rd, 5'd0);
            1:  word = make_rtype(FN_SUBU, rs, rt, rd, 5'd0);
            2:  word = make_rtype(FN_AND, rs, rt, rd, 5'd0);
            3:  word = make_rtype(FN_OR, rs, rt, rd, 5'd0);
            4:  word = make_rtype(FN_XOR, rs, rt, rd, 5'd0);
            5:  word = make_rtype(FN_SLT, rs, rt, rd, 5'd0);
            6:  word = make_rtype(FN_SLL, 5'd0, rt, rd, 5'($urandom));
            7:  word = make_rtype(FN_SRL, 5'd0, rt, rd, 5'($urandom));
            8:  word = make_itype(OP_ADDIU, rs, rt, imm);
            9:  word = make_itype(OP_SLTI, rs, rt, imm);
            10: word = make_itype(OP_ANDI, rs, rt, imm);
            11: word = make_itype(OP_ORI, rs, rt, imm);
            12: word = make_itype(OP_XORI, rs, rt, imm);
            13: word = make_itype(OP_LUI, 5'd0, rt, imm);
            14: word = make_itype(OP_LW, 5'd0, rt, offs);
            15: word = make_itype(OP_SW, 5'd0, rt, offs);
            // unsupported opcode must act as a nop
            default: word = {6'h1c, 26'($urandom)};
        endcase
        return word;
    endfunction

    task automatic build_program();
        int k;
        int off;
        int last;
        last = PROLOGUE + BODY_LEN;
        for (k = 0; k < IMEM_WORDS; k++) begin
            prog[k] = 32'h0;
        end
        // prologue gives every register a known value
        for (k = 1; k <= PROLOGUE; k++) begin
            prog[k - 1] = make_itype(OP_ADDIU, 5'd0, 5'(k), 16'($urandom));
        end
        k = PROLOGUE;
        while (k < last) begin
            if (k + 2 < last && $urandom_range(5, 0) == 0) begin
                // forward only and at most up to the final jump
                off = int'($urandom_range(8, 1));
                if (k + 1 + off > last) begin
                    off = last - k - 1;
                end
                case ($urandom_range(2, 0))
                    0: prog[k] = make_itype(OP_BEQ, random_reg(), random_reg(), 16'(off));
                    1: prog[k] = make_itype(OP_BNE, random_reg(), random_reg(), 16'(off));
                    default: prog[k] = make_jump(RESET_PC + 32'((k + 1 + off) * 4));
                endcase
                prog[k + 1] = random_plain();
                k += 2;
            end else begin
                prog[k] = random_plain();
                k++;
            end
        end
        // self loop with a nop slot ends the program
        final_pc = RESET_PC + 32'(last * 4);
        prog[last] = make_jump(final_pc);
    endtask

    task automatic fill_data(input int run_id);
        for (int i = 0; i < 64; i++) begin
            ram[i]   = (32'(i) * 32'h9e37_79b1) ^ {8'(run_id), 24'h5a_c3a5};
            mdata[i] = ram[i];
        end
    endtask

    // in-order ISA model with one delay slot
    task automatic run_model();
        instr_t      ins;
        logic [31:0] cur;
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] ea;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        int          steps;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = 32'h0;
        end
        pc    = RESET_PC;
        npc   = RESET_PC + 32'd4;
        cur   = 32'h0;
        steps = 0;
        while (cur != final_pc && steps < 2000) begin
            cur  = pc;
            ins  = fetch_word(cur);
            pc   = npc;
            npc  = npc + 32'd4;
            a    = mregs[ins.r.rs];
            b    = mregs[ins.r.rt];
            simm = {{16{ins.i.imm[15]}}, ins.i.imm};
            zimm = {16'h0000, ins.i.imm};
            ea   = a + simm;
            dst  = (ins.r.op == OP_SPECIAL) ? ins.r.rd : ins.i.rt;
            res  = 32'h0;
            wr   = 1'b1;
            case (ins.r.op)
                OP_SPECIAL: begin
                    case (ins.r.funct)
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  res = b << ins.r.shamt;
                        FN_SRL:  res = b >> ins.r.shamt;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + simm;
                OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                OP_ANDI:  res = a & zimm;
                OP_ORI:   res = a | zimm;
                OP_XORI:  res = a ^ zimm;
                OP_LUI:   res = {ins.i.imm, 16'h0000};
                OP_LW:    res = mdata[ea[7:2]];
                OP_SW: begin
                    wr = 1'b0;
                    mdata[ea[7:2]] = b;
                    st_addr.push_back(ea);
                    st_data.push_back(b);
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b) begin
                        npc = pc + (simm << 2);
                    end
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (a != b) begin
                        npc = pc + (simm << 2);
                    end
                end
                OP_J: begin
                    wr = 1'b0;
                    npc = {pc[31:28], ins.j.target, 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                mregs[dst] = res;
                exp_pc.push_back(cur);
                exp_num.push_back(dst);
                exp_val.push_back(res);
            end
            steps++;
        end
    endtask

    task automatic check_writeback();
        logic [31:0] pc;
        logic [4:0]  num;
        logic [31:0] val;
        assert (exp_pc.size() != 0) else begin
            errors++;
            $display("unexpected writeback to r%0d at %0t ns, nothing left to expect",
                     debug_wb_rf_wnum, $time);
        end
        if (exp_pc.size() != 0) begin
            pc  = exp_pc.pop_front();
            num = exp_num.pop_front();
            val = exp_val.pop_front();
            compare_word("debug_wb_pc", pc, debug_wb_pc);
            compare_word("debug_wb_rf_wnum", {27'h0, num}, {27'h0, debug_wb_rf_wnum});
            compare_word("debug_wb_rf_wdata", val, debug_wb_rf_wdata);
            compare_word("debug_wb_rf_wen", 32'hf, {28'h0, debug_wb_rf_wen});
            // fetched exactly two cycles earlier
            compare_word("inst_sram_addr two cycles back", pc, fetch_d2);
        end
    endtask

    task automatic check_store();
        logic [31:0] addr;
        logic [31:0] data;
        assert (st_addr.size() != 0) else begin
            errors++;
            $display("unexpected store to %h at %0t ns, nothing left to expect",
                     data_sram_addr, $time);
        end
        if (st_addr.size() != 0) begin
            addr = st_addr.pop_front();
            data = st_data.pop_front();
            compare_word("data_sram_addr", addr, data_sram_addr);
            compare_word("data_sram_wdata", data, data_sram_wdata);
            compare_word("data_sram_wen", 32'hf, {28'h0, data_sram_wen});
        end
    endtask

    // sram models take the request mid cycle
    always @(negedge clk) begin
        if (inst_sram_en) begin
            inst_next = fetch_word(inst_sram_addr);
        end
        if (data_sram_en && data_sram_wen == 4'h0) begin
            data_next = ram[data_sram_addr[7:2]];
        end else if (data_sram_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (data_sram_wen[lane]) begin
                    ram[data_sram_addr[7:2]][8 * lane +: 8] = data_sram_wdata[8 * lane +: 8];
                end
            end
        end
    end

    // read data lands just after the edge
    always @(posedge clk) begin
        #DRIVE_DELAY;
        inst_sram_rdata = inst_next;
        data_sram_rdata = data_next;
    end

    // outputs sampled at the falling edge
    always @(negedge clk) begin
        // fetch port reads every cycle and never writes
        compare_word("inst_sram_en", 32'h1, {31'h0, inst_sram_en});
        compare_word("inst_sram_wen", 32'h0, {28'h0, inst_sram_wen});
        compare_word("inst_sram_wdata", 32'h0, inst_sram_wdata);
        if (!rst_n || cyc < 2) begin
            compare_word("debug_wb_rf_wen", 32'h0, {28'h0, debug_wb_rf_wen});
            compare_word("data_sram_en", 32'h0, {31'h0, data_sram_en});
            compare_word("data_sram_wen", 32'h0, {28'h0, data_sram_wen});
        end
        if (!rst_n || cyc == 0) begin
            compare_word("inst_sram_addr", RESET_PC, inst_sram_addr);
        end
        if (!rst_n) begin
            cyc      = 0;
            fetch_d1 = inst_sram_addr;
            fetch_d2 = inst_sram_addr;
        end else begin
            if (debug_wb_rf_wen != 4'h0) begin
                check_writeback();
            end
            if (data_sram_en && data_sram_wen != 4'h0) begin
                check_store();
            end
            fetch_d2 = fetch_d1;
            fetch_d1 = inst_sram_addr;
            cyc++;
        end
    end

    task automatic wait_for_drain(input int run_id);
        int n;
        n = 0;
        while ((exp_pc.size() != 0 || st_addr.size() != 0) && n < RUN_CYCLES) begin
            @(posedge clk);
            n++;
        end
        // final loop spins and nothing more may show up
        repeat (TAIL_CYCLES) @(posedge clk);
        assert (exp_pc.size() == 0 && st_addr.size() == 0) else begin
            errors++;
            $display("run %0d ended with %0d writebacks and %0d stores still missing",
                     run_id, exp_pc.size(), st_addr.size());
        end
        exp_pc.delete();
        exp_num.delete();
        exp_val.delete();
        st_addr.delete();
        st_data.delete();
    endtask

    initial begin
        #(NUM_RUNS * 600 * CLK_PERIOD);
        $display("watchdog expired before the last run finished");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        inst_next       = 32'h0;
        data_next       = 32'h0;
        cyc             = 0;
        errors          = 0;
        void'($urandom(SEED));
        for (int run_id = 0; run_id < NUM_RUNS; run_id++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            rst_n = 1'b0;
            // new image only while the core is held in reset
            build_program();
            fill_data(run_id);
            run_model();
            repeat (2) @(posedge clk);
            #DRIVE_DELAY;
            rst_n = 1'b1;
            wait_for_drain(run_id);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hdl/cpu_pkg.sv
hdl/sram_if.sv
hdl/wb_if.sv
hdl/alu.sv
hdl/regfile.sv
hdl/decoder.sv
hdl/datapath.sv
hdl/mycpu_top.sv
tb/tb_cpu.sv

//--- run.sh
#!/usr/bin/env bash
# build tb_cpu with verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cpu -f project.f &&
./obj_dir/Vtb_cpu | tee /dev/stderr | grep -F "ALL CHECKS PASSED" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
